// ==== src/instrCachePkg.sv ====
`default_nettype none

package instrCachePkg;

    // Cache geometry
    localparam int blockBytes = 16;
    localparam int blockWords = blockBytes / 4;
    localparam int numWays    = 4;
    localparam int numSets    = 4;
    localparam int addrWidth  = 32;

    // Address split, derived from the geometry above
    localparam int offsetBits = $clog2(blockBytes);
    localparam int indexBits  = $clog2(numSets);
    localparam int tagBits    = addrWidth - indexBits - offsetBits;
    localparam int wayBits    = $clog2(numWays);

    typedef logic [addrWidth-1:0]      addrT;
    typedef logic [31:0]               wordT;
    typedef logic [tagBits-1:0]        tagT;
    typedef logic [indexBits-1:0]      indexT;
    typedef logic [offsetBits-1:0]     offsetT;
    // Way number, doubles as LRU age
    typedef logic [wayBits-1:0]        wayT;
    // Word 0 sits in the low bits
    typedef logic [blockBytes*8-1:0]   blockT;

    // Fetch stage request
    typedef struct packed {
        logic valid;
        addrT addr;
    } fetchReqT;

    // APB master to slave
    typedef struct packed {
        logic psel;
        logic penable;
        addrT paddr;
    } apbReqT;

    // APB slave to master, pslverr not carried
    typedef struct packed {
        logic pready;
        wordT prdata;
    } apbRspT;

    typedef enum logic [1:0] {
        idle,
        setup,
        access,
        done
    } refillStateT;

endpackage

`default_nettype wire

// ==== src/instrCacheSet.sv ====
`default_nettype none
`timescale 1ns/1ps

module instrCacheSet (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  activeSet,
    input  logic                  refillStrobe,
    input  instrCachePkg::tagT    tag,
    input  instrCachePkg::offsetT offset,
    input  instrCachePkg::blockT  refillBlock,
    output instrCachePkg::wordT   word,
    output logic                  miss
);
    import instrCachePkg::*;

    // Per-way tags and blocks
    tagT   tags   [numWays];
    blockT blocks [numWays];

    // Control state
    logic [numWays-1:0] valid;
    wayT                ages [numWays];
    wayT                fillPtr;

    // Lookup results
    logic [numWays-1:0] hitVec;
    wayT                hitWay;
    wayT                hitAge;
    wayT                victimWay;
    wayT                replaceWay;
    logic               setFull;
    blockT              hitBlock;
    blockT              shiftedBlock;

    // Tag compare against every valid way
    always_comb begin
        hitVec = '0;
        hitWay = '0;
        hitAge = '0;
        for (int w = 0; w < numWays; w++) begin
            if (valid[w] && tags[w] == tag) begin
                hitVec[w] = 1'b1;
                hitWay    = wayT'(w);
                hitAge    = ages[w];
            end
        end
    end

    // Only the enabled set may report a miss
    assign miss = activeSet && (hitVec == '0);

    // Oldest way is the one at the top age
    always_comb begin
        victimWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (ages[w] == wayT'(numWays - 1)) begin
                victimWay = wayT'(w);
            end
        end
    end

    assign setFull    = &valid;
    // Free ways are filled in order before any eviction
    assign replaceWay = setFull ? victimWay : fillPtr;

    // LRU ages, valid bits and fill pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            valid   <= '0;
            fillPtr <= '0;
            for (int w = 0; w < numWays; w++) begin
                ages[w] <= '0;
            end
        end else if (activeSet && !miss) begin
            // Hit way becomes youngest and younger ones age by one
            for (int w = 0; w < numWays; w++) begin
                if (hitVec[w]) begin
                    ages[w] <= '0;
                end else if (valid[w] && ages[w] < hitAge) begin
                    ages[w] <= ages[w] + 1'b1;
                end
            end
        end else if (activeSet && refillStrobe) begin
            if (!setFull) begin
                valid[fillPtr] <= 1'b1;
                fillPtr        <= fillPtr + 1'b1;
                for (int w = 0; w < numWays; w++) begin
                    if (wayT'(w) == fillPtr) begin
                        ages[w] <= '0;
                    end else if (valid[w]) begin
                        ages[w] <= ages[w] + 1'b1;
                    end
                end
            end else begin
                // In a full set the victim restarts at zero and everyone else ages
                for (int w = 0; w < numWays; w++) begin
                    if (wayT'(w) == victimWay) begin
                        ages[w] <= '0;
                    end else begin
                        ages[w] <= ages[w] + 1'b1;
                    end
                end
            end
        end
    end

    // Install the new block and its tag
    always_ff @(posedge clk) begin
        if (activeSet && refillStrobe && miss) begin
            tags[replaceWay]   <= tag;
            blocks[replaceWay] <= refillBlock;
        end
    end

    // Byte offset shifts the wanted word down to bit 0
    assign hitBlock     = blocks[hitWay];
    assign shiftedBlock = hitBlock >> {offset, 3'b000};
    assign word         = shiftedBlock[$bits(wordT)-1:0];

endmodule

`default_nettype wire

// ==== src/instrCacheArray.sv ====
`default_nettype none
`timescale 1ns/1ps

module instrCacheArray (
    input  logic                    clk,
    input  logic                    reset,
    input  instrCachePkg::fetchReqT fetchReq,
    input  logic                    refillStrobe,
    input  instrCachePkg::blockT    refillBlock,
    output instrCachePkg::wordT     instr,
    output logic                    miss,
    output instrCachePkg::addrT     lookupAddr
);
    import instrCachePkg::*;

    // Address fields
    tagT    tag;
    indexT  index;
    offsetT offset;

    // Per-set enables and results
    logic [numSets-1:0] activeSets;
    logic [numSets-1:0] setMiss;
    wordT               setWord [numSets];

    assign tag    = fetchReq.addr[addrWidth-1 -: tagBits];
    assign index  = fetchReq.addr[offsetBits +: indexBits];
    assign offset = fetchReq.addr[offsetBits-1:0];

    // Block-aligned address for the refill engine
    assign lookupAddr = {fetchReq.addr[addrWidth-1:offsetBits], {offsetBits{1'b0}}};

    for (genvar s = 0; s < numSets; s++) begin : gSet
        // One-hot set enable, nothing enabled without a request
        assign activeSets[s] = fetchReq.valid && (index == indexT'(s));

        instrCacheSet uSet (
            .clk          (clk),
            .reset        (reset),
            .activeSet    (activeSets[s]),
            .refillStrobe (refillStrobe && activeSets[s]),
            .tag          (tag),
            .offset       (offset),
            .refillBlock  (refillBlock),
            .word         (setWord[s]),
            .miss         (setMiss[s])
        );
    end

    // Inactive sets never raise miss
    assign miss = |setMiss;

    // Word of the enabled set only
    always_comb begin
        instr = '0;
        for (int s = 0; s < numSets; s++) begin
            if (activeSets[s]) begin
                instr = instr | setWord[s];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/blockRefill.sv ====
`default_nettype none
`timescale 1ns/1ps

module blockRefill (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  miss,
    input  instrCachePkg::addrT   lookupAddr,
    input  instrCachePkg::apbRspT apbRsp,
    output instrCachePkg::apbReqT apbReq,
    output instrCachePkg::blockT  refillBlock,
    output logic                  refillStrobe
);
    import instrCachePkg::*;

    refillStateT state;
    refillStateT stateNext;

    // Word within the block being read
    logic [offsetBits-3:0] wordCnt;
    logic                  lastWord;
    logic                  wordDone;

    assign lastWord = wordCnt == (offsetBits - 2)'(blockWords - 1);
    // Access phase completes on pready
    assign wordDone = (state == access) && apbRsp.pready;

    // Next state
    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (miss) begin
                    stateNext = setup;
                end
            end
            setup: begin
                stateNext = access;
            end
            access: begin
                if (apbRsp.pready) begin
                    stateNext = lastWord ? done : setup;
                end
            end
            done: begin
                // Strobe clears the miss, so no restart here
                stateNext = idle;
            end
            default: begin
                stateNext = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            wordCnt <= '0;
        end else begin
            state <= stateNext;
            if (wordDone) begin
                // Wraps back to zero after the last word
                wordCnt <= wordCnt + 1'b1;
            end
        end
    end

    // Shift in from the top, word 0 ends up lowest
    always_ff @(posedge clk) begin
        if (wordDone) begin
            refillBlock <= {apbRsp.prdata, refillBlock[$bits(blockT)-1:$bits(wordT)]};
        end
    end

    // APB request, paddr held through the access phase
    always_comb begin
        apbReq.psel    = (state == setup) || (state == access);
        apbReq.penable = state == access;
        apbReq.paddr   = lookupAddr | addrT'({wordCnt, 2'b00});
    end

    // One cycle install pulse
    assign refillStrobe = state == done;

endmodule

`default_nettype wire

// ==== src/instrCache.sv ====
`default_nettype none
`timescale 1ns/1ps

module instrCache (
    input  logic                    clk,
    input  logic                    reset,
    input  instrCachePkg::fetchReqT fetchReq,
    input  instrCachePkg::apbRspT   apbRsp,
    output instrCachePkg::wordT     instr,
    output logic                    stall,
    output instrCachePkg::apbReqT   apbReq
);
    import instrCachePkg::*;

    // Array to refill engine
    addrT  lookupAddr;
    // Refill engine back to array
    blockT refillBlock;
    logic  refillStrobe;

    // Lookup and storage, miss doubles as the core stall
    instrCacheArray uArray (
        .clk          (clk),
        .reset        (reset),
        .fetchReq     (fetchReq),
        .refillStrobe (refillStrobe),
        .refillBlock  (refillBlock),
        .instr        (instr),
        .miss         (stall),
        .lookupAddr   (lookupAddr)
    );

    // APB master fetching the missing block
    blockRefill uRefill (
        .clk          (clk),
        .reset        (reset),
        .miss         (stall),
        .lookupAddr   (lookupAddr),
        .apbRsp       (apbRsp),
        .apbReq       (apbReq),
        .refillBlock  (refillBlock),
        .refillStrobe (refillStrobe)
    );

endmodule

`default_nettype wire

// ==== dv/apbMemModel.sv ====
`default_nettype none
`timescale 1ns/1ps

module apbMemModel (
    input  logic                  clk,
    input  logic                  reset,
    input  instrCachePkg::apbReqT apbReq,
    output instrCachePkg::apbRspT apbRsp
);
    import instrCachePkg::*;

    // Wait cycles left in the current access phase
    logic [1:0] waitLeft;
    logic       accessPhase;
    logic       ready;

    // Contents are a fixed hash of the word address
    function automatic wordT memWord(addrT addr);
        return (addr >> 2) * 32'h6D2B79F5 + 32'h1F35A7C3;
    endfunction

    assign accessPhase = apbReq.psel && apbReq.penable;

    always @(posedge clk) begin
        if (reset) begin
            waitLeft <= '0;
        end else if (apbReq.psel && !apbReq.penable) begin
            // Fresh 0 to 3 wait states for every setup phase
            waitLeft <= 2'($urandom % 4);
        end else if (accessPhase && waitLeft != 0) begin
            waitLeft <= waitLeft - 1'b1;
        end
    end

    assign ready  = accessPhase && (waitLeft == 0);
    // Data only driven alongside pready
    assign apbRsp = {ready, ready ? memWord(apbReq.paddr) : 32'h0};

endmodule

`default_nettype wire

// ==== dv/instrCacheTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module instrCacheTb;
    import instrCachePkg::*;

    localparam int numFetches  = 400;
    localparam int resetCycles = 8;
    // Worst-case miss with three wait states on every word
    localparam int missCycles  = 21;
    localparam int cycleLimit  = resetCycles + numFetches * missCycles + 200;
    // More tags per set than numWays so sets overflow
    localparam int tagPool     = 6;

    logic     clk;
    logic     reset;
    fetchReqT fetchReq;
    apbRspT   apbRsp;
    wordT     instr;
    logic     stall;
    apbReqT   apbReq;

    int errorCount;
    int fetchCount;
    int cycleCount;

    // Completed APB reads since the last fetch check
    addrT apbAddrs[$];

    // Reference tag store with LRU ages and fill counters
    tagT  modelTags  [numSets][numWays];
    logic modelValid [numSets][numWays];
    int   modelAges  [numSets][numWays];
    int   modelFill  [numSets];

    // Values from the previous edge
    apbReqT   prevReq;
    logic     prevReady;

    instrCache DUT (
        .clk      (clk),
        .reset    (reset),
        .fetchReq (fetchReq),
        .apbRsp   (apbRsp),
        .instr    (instr),
        .stall    (stall),
        .apbReq   (apbReq)
    );

    apbMemModel uMem (
        .clk    (clk),
        .reset  (reset),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #5 clk = ~clk;

    task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic reportProblem(string msg);
        $display("Error at %0t: %s", $time, msg);
        errorCount++;
    endtask

    // Word address times an odd constant plus an offset
    function automatic wordT expectedInstr(addrT addr);
        return (addr >> 2) * 32'h6D2B79F5 + 32'h1F35A7C3;
    endfunction

    function automatic int findWay(indexT set, tagT tag);
        for (int w = 0; w < numWays; w++) begin
            if (modelValid[set][w] && modelTags[set][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Used way goes to age 0 and ways younger than it get one older
    function automatic void touchWay(indexT set, int way);
        int oldAge;
        oldAge = modelAges[set][way];
        for (int w = 0; w < numWays; w++) begin
            if (w == way) begin
                modelAges[set][w] = 0;
            end else if (modelValid[set][w] && modelAges[set][w] < oldAge) begin
                modelAges[set][w]++;
            end
        end
    endfunction

    function automatic int installBlock(indexT set, tagT tag);
        int way;
        way = modelFill[set];
        if (way < numWays) begin
            // Free ways fill in order while valid ones age
            for (int w = 0; w < numWays; w++) begin
                if (modelValid[set][w]) begin
                    modelAges[set][w]++;
                end
            end
            modelValid[set][way] = 1'b1;
            modelFill[set]++;
        end else begin
            // Oldest way of a full set is evicted
            for (int w = 0; w < numWays; w++) begin
                if (modelAges[set][w] == numWays - 1) begin
                    way = w;
                end
                modelAges[set][w]++;
            end
        end
        modelAges[set][way] = 0;
        modelTags[set][way] = tag;
        return way;
    endfunction

    function automatic fetchReqT randomFetch();
        fetchReqT req;
        tagT      tag;
        tag       = tagT'(26'h04A10 + ($urandom % tagPool) * 26'h35);
        req.valid = ($urandom % 8) != 0;
        req.addr  = {tag, indexT'($urandom), 2'($urandom), 2'b00};
        return req;
    endfunction

    // Present one request and check it against the model
    task automatic runFetch(fetchReqT req);
        indexT set;
        tagT   tag;
        addrT  aligned;
        int    way;
        set     = req.addr[offsetBits +: indexBits];
        tag     = req.addr[addrWidth-1 -: tagBits];
        aligned = {req.addr[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
        @(posedge clk);
        fetchReq <= req;
        @(negedge clk);
        if (!req.valid) begin
            if (stall) begin
                reportProblem("stall high without a valid request");
            end
            return;
        end
        fetchCount++;
        way = findWay(set, tag);
        if (way < 0) begin
            if (!stall) begin
                reportMismatch("stall", 1, stall);
            end
            // Request stays held until the refill finishes
            while (stall) begin
                @(negedge clk);
            end
            way = installBlock(set, tag);
            if (apbAddrs.size() != blockWords) begin
                reportProblem($sformatf("miss at %h gave %0d APB reads, not %0d",
                                        req.addr, apbAddrs.size(), blockWords));
            end else begin
                for (int k = 0; k < blockWords; k++) begin
                    if (apbAddrs[k] !== addrT'(aligned + 4 * k)) begin
                        reportMismatch("apbReq.paddr", aligned + 4 * k, apbAddrs[k]);
                    end
                end
            end
        end else begin
            if (stall) begin
                reportMismatch("stall", 0, stall);
            end
            while (stall) begin
                @(negedge clk);
            end
            if (apbAddrs.size() != 0) begin
                reportProblem($sformatf("hit at %h caused APB reads", req.addr));
            end
        end
        touchWay(set, way);
        if (instr !== expectedInstr(req.addr)) begin
            reportMismatch("instr", expectedInstr(req.addr), instr);
        end
        apbAddrs.delete();
    endtask

    // APB protocol and back-pressure monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (apbReq.penable && !prevReq.penable && !(prevReq.psel && !prevReq.penable)) begin
                reportProblem("penable rose without a setup cycle before it");
            end
            if (apbReq.penable && !apbReq.psel) begin
                reportProblem("penable high while psel low");
            end
            // Address must hold until pready
            if (prevReq.penable && !prevReady) begin
                if (!apbReq.penable) begin
                    reportProblem("access phase dropped before pready");
                end else if (apbReq.paddr !== prevReq.paddr) begin
                    reportMismatch("apbReq.paddr", prevReq.paddr, apbReq.paddr);
                end
            end
            if (apbReq.psel && !prevReq.psel && !stall) begin
                reportProblem("psel rose while stall was low");
            end
            // Refill reads stay inside the block of the held request
            if (apbReq.psel && (!fetchReq.valid
                    || apbReq.paddr[addrWidth-1:offsetBits]
                       !== fetchReq.addr[addrWidth-1:offsetBits])) begin
                reportProblem("APB read outside the block of the held fetch address");
            end
            if (apbReq.psel && apbReq.penable && apbRsp.pready) begin
                apbAddrs.push_back(apbReq.paddr);
            end
        end
        prevReq   <= apbReq;
        prevReady <= apbRsp.pready;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d fetches checked", cycleCount, fetchCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        fetchReqT req;
        void'($urandom(32'h89528c9b));
        clk        = 1'b0;
        reset      = 1'b1;
        fetchReq   = '0;
        errorCount = 0;
        fetchCount = 0;
        cycleCount = 0;
        for (int s = 0; s < numSets; s++) begin
            modelFill[s] = 0;
            for (int w = 0; w < numWays; w++) begin
                modelValid[s][w] = 1'b0;
                modelAges[s][w]  = 0;
                modelTags[s][w]  = '0;
            end
        end
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        // Idle cache straight after reset
        @(negedge clk);
        if (stall) begin
            reportMismatch("stall", 0, stall);
        end
        if (apbReq.psel) begin
            reportMismatch("apbReq.psel", 0, apbReq.psel);
        end
        if (apbReq.penable) begin
            reportMismatch("apbReq.penable", 0, apbReq.penable);
        end
        for (int i = 0; i < numFetches; i++) begin
            req = randomFetch();
            runFetch(req);
        end
        @(negedge clk);
        $display("Errors: %0d, fetches checked: %0d", errorCount, fetchCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/instrCachePkg.sv
src/instrCacheSet.sv
src/instrCacheArray.sv
src/blockRefill.sv
src/instrCache.sv
dv/apbMemModel.sv
dv/instrCacheTb.sv

// ==== Bender.yml ====
package:
  name: instrCache

sources:
  - src/instrCachePkg.sv
  - src/instrCacheSet.sv
  - src/instrCacheArray.sv
  - src/blockRefill.sv
  - src/instrCache.sv
  - target: test
    files:
      - dv/apbMemModel.sv
      - dv/instrCacheTb.sv
